//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_dcache -f build.f
	@out="$$(./obj_dir/Vtb_dcache)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+common
common/dcache_pkg.sv
dcache/dcache_ctrl.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_store.sv
dcache/dcache_top.sv
sim/tb_mem_slave.sv
sim/tb_dcache.sv

//--- common/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address split is tag | index | word select | byte
`define DC_TAG_W 19
`define DC_INDEX_W 7
`define DC_WORD_SEL_W 4

// 128 lines of 64 bytes
`define DC_LINES 128
`define DC_WORDS_PER_LINE 16

// encoded as beats minus one
`define DC_BURST_LEN 15

// same code the cpu uses for a 32-bit access
`define DC_SIZE_WORD 4'b0100

// everything from here up bypasses the cache
`define DC_UNCACHE_BASE 32'hA000_0000

`endif

//--- common/dcache_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

  typedef logic [`DC_TAG_W-1:0] dc_tag_t;

  typedef logic [`DC_INDEX_W-1:0] dc_index_t;

  typedef logic [`DC_WORD_SEL_W-1:0] dc_word_sel_t;

  // msb first, matches the cpu byte address
  typedef struct packed {
    dc_tag_t      tag;
    dc_index_t    index;
    dc_word_sel_t word_sel;
    logic [1:0]   byte_sel;
  } dc_addr_fields_t;

  // one cpu address seen both ways
  typedef union packed {
    logic [31:0]     raw;
    dc_addr_fields_t f;
  } dc_addr_u;

endpackage

`default_nettype wire

//--- dcache/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     mem_valid_i,
  input  logic                     mem_write_i,
  input  dcache_pkg::dc_addr_u     mem_addr_i,
  input  logic [3:0]               mem_mask_i,
  input  logic [3:0]               mem_size_i,
  input  logic [31:0]              mem_wdata_i,
  output logic [31:0]              mem_rdata_o,
  output logic                     mem_ready_o,
  output logic [31:0]              ram_raddr_o,
  output logic                     ram_raddr_valid_o,
  output logic [7:0]               ram_rlen_o,
  output logic [3:0]               ram_rsize_o,
  input  logic                     ram_rdata_ready_i,
  input  logic [31:0]              ram_rdata_i,
  output logic [31:0]              ram_waddr_o,
  output logic                     ram_waddr_valid_o,
  output logic [3:0]               ram_wmask_o,
  output logic [3:0]               ram_wsize_o,
  output logic [7:0]               ram_wlen_o,
  output logic [31:0]              ram_wdata_o,
  input  logic                     ram_wdata_ready_i,
  input  logic                     hit_i,
  input  logic                     dirty_i,
  input  dcache_pkg::dc_tag_t      victim_tag_i,
  input  logic [31:0]              line_word_i,
  output dcache_pkg::dc_index_t    tag_index_o,
  output dcache_pkg::dc_tag_t      tag_o,
  output logic                     tag_wen_o,
  output logic                     dirty_o,
  output dcache_pkg::dc_word_sel_t data_word_sel_o,
  output logic                     data_wen_o,
  output logic [3:0]               data_wmask_o,
  output logic [31:0]              data_wdata_o
);
  import dcache_pkg::*;

  localparam logic [2:0] S_RESET      = 3'd0;
  localparam logic [2:0] S_IDLE       = 3'd1;
  localparam logic [2:0] S_WRITE_BACK = 3'd2;
  localparam logic [2:0] S_REFILL     = 3'd3;
  localparam logic [2:0] S_UNC_READ   = 3'd4;
  localparam logic [2:0] S_UNC_WRITE  = 3'd5;

  logic [2:0]   state;
  dc_word_sel_t burst_cnt;
  logic         ready_q;
  logic [31:0]  uncache_rdata;
  logic [31:0]  uncache_wdata;

  logic         uncached;
  logic         req;
  logic         rd_beat;
  logic         wr_beat;
  logic         last_beat;
  logic         in_burst;
  logic         refill_beat;
  logic         read_hit;
  logic         write_hit;
  logic         go_unc_rd;
  logic         go_unc_wr;
  logic         go_wb;
  logic         go_refill;
  logic [31:0]  line_addr;
  logic [31:0]  victim_addr;

  assign uncached  = mem_addr_i.raw >= `DC_UNCACHE_BASE;
  assign req       = (state == S_IDLE) && mem_valid_i && !ready_q; // ignore during ready
  assign rd_beat   = ram_raddr_valid_o && ram_rdata_ready_i;
  assign wr_beat   = ram_waddr_valid_o && ram_wdata_ready_i;
  assign last_beat = burst_cnt == dc_word_sel_t'(`DC_BURST_LEN);
  assign in_burst  = (state == S_WRITE_BACK) || (state == S_REFILL);

  assign line_addr   = {mem_addr_i.f.tag, mem_addr_i.f.index, {(`DC_WORD_SEL_W + 2){1'b0}}};
  assign victim_addr = {victim_tag_i, mem_addr_i.f.index, {(`DC_WORD_SEL_W + 2){1'b0}}};

  assign read_hit  = req && !uncached && hit_i && !mem_write_i;
  assign write_hit = req && !uncached && hit_i && mem_write_i;
  assign go_unc_rd = req && uncached && !mem_write_i;
  assign go_unc_wr = req && uncached && mem_write_i;
  assign go_wb     = req && !uncached && !hit_i && dirty_i;
  // clean miss, or the victim is already out
  assign go_refill = (req && !uncached && !hit_i && !dirty_i) ||
                     ((state == S_WRITE_BACK) && wr_beat && last_beat);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state             <= S_RESET;
      burst_cnt         <= '0;
      ready_q           <= 1'b0;
      ram_raddr_valid_o <= 1'b0;
      ram_waddr_valid_o <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state)
        S_RESET: begin
          state <= S_IDLE;
        end
        S_IDLE: begin
          burst_cnt <= '0;
          if (read_hit || write_hit) begin
            ready_q <= 1'b1;
          end else if (go_unc_rd) begin
            ram_raddr_valid_o <= 1'b1;
            state             <= S_UNC_READ;
          end else if (go_unc_wr) begin
            ram_waddr_valid_o <= 1'b1;
            state             <= S_UNC_WRITE;
          end else if (go_wb) begin
            ram_waddr_valid_o <= 1'b1;
            state             <= S_WRITE_BACK;
          end else if (go_refill) begin
            ram_raddr_valid_o <= 1'b1;
            state             <= S_REFILL;
          end
        end
        S_WRITE_BACK: begin
          if (wr_beat) begin
            burst_cnt <= burst_cnt + 1'b1; // wraps to 0 for the refill
            if (last_beat) begin
              ram_waddr_valid_o <= 1'b0;
              ram_raddr_valid_o <= 1'b1;
              state             <= S_REFILL;
            end
          end
        end
        S_REFILL: begin
          if (rd_beat) begin
            burst_cnt <= burst_cnt + 1'b1;
            if (last_beat) begin
              ram_raddr_valid_o <= 1'b0;
              state             <= S_IDLE; // request is looked up again
            end
          end
        end
        S_UNC_READ: begin
          if (rd_beat) begin
            ram_raddr_valid_o <= 1'b0;
            ready_q           <= 1'b1;
            state             <= S_IDLE;
          end
        end
        S_UNC_WRITE: begin
          if (wr_beat) begin
            ram_waddr_valid_o <= 1'b0;
            ready_q           <= 1'b1;
            state             <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // request payload, loaded as a transfer starts
  always_ff @(posedge clk) begin
    if (go_refill) begin
      ram_raddr_o <= line_addr;
      ram_rlen_o  <= 8'(`DC_BURST_LEN);
      ram_rsize_o <= `DC_SIZE_WORD;
    end else if (go_unc_rd) begin
      ram_raddr_o <= mem_addr_i.raw;
      ram_rlen_o  <= 8'd0;
      ram_rsize_o <= mem_size_i;
    end
    if (go_wb) begin
      ram_waddr_o <= victim_addr;
      ram_wlen_o  <= 8'(`DC_BURST_LEN);
      ram_wsize_o <= `DC_SIZE_WORD;
      ram_wmask_o <= 4'hF;
    end else if (go_unc_wr) begin
      ram_waddr_o   <= mem_addr_i.raw;
      ram_wlen_o    <= 8'd0;
      ram_wsize_o   <= mem_size_i;
      ram_wmask_o   <= mem_mask_i;
      uncache_wdata <= mem_wdata_i;
    end
    if ((state == S_UNC_READ) && rd_beat) begin
      uncache_rdata <= ram_rdata_i;
    end
  end

  assign refill_beat = (state == S_REFILL) && rd_beat;

  assign tag_index_o = mem_addr_i.f.index;
  assign tag_o       = mem_addr_i.f.tag;
  assign tag_wen_o   = write_hit || (refill_beat && last_beat);
  assign dirty_o     = write_hit; // refill leaves the line clean

  assign data_word_sel_o = in_burst ? burst_cnt : mem_addr_i.f.word_sel;
  assign data_wen_o      = write_hit || refill_beat;
  assign data_wmask_o    = refill_beat ? 4'hF : mem_mask_i;
  assign data_wdata_o    = refill_beat ? ram_rdata_i : mem_wdata_i;

  assign ram_wdata_o = (state == S_WRITE_BACK) ? line_word_i : uncache_wdata;
  assign mem_rdata_o = uncached ? uncache_rdata : line_word_i;
  assign mem_ready_o = ready_q;

  a_one_channel: assert property (@(posedge clk) disable iff (rst)
    !(ram_raddr_valid_o && ram_waddr_valid_o));

  // the cpu sees each completion exactly once
  a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
    mem_ready_o |=> !mem_ready_o);

endmodule

`default_nettype wire

//--- dcache/dcache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_data_store (
  input  logic                     clk,
  input  dcache_pkg::dc_index_t    index_i,
  input  dcache_pkg::dc_word_sel_t word_sel_i,
  input  logic                     wen_i,
  input  logic [3:0]               wmask_i,
  input  logic [31:0]              wdata_i,
  output logic [31:0]              rdata_o
);

  localparam int unsigned DEPTH  = `DC_LINES * `DC_WORDS_PER_LINE;
  localparam int unsigned ADDR_W = `DC_INDEX_W + `DC_WORD_SEL_W;

  logic [31:0]       mem [0:DEPTH-1];
  logic [ADDR_W-1:0] addr;

  // word address inside the whole cache
  assign addr = {index_i, word_sel_i};

  always_ff @(posedge clk) begin
    if (wen_i) begin
      for (int b = 0; b < 4; b++) begin
        if (wmask_i[b]) begin
          mem[addr][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // combinational read, old data during a write
  assign rdata_o = mem[addr];

  a_no_empty_write: assert property (@(posedge clk)
    wen_i |-> (wmask_i != 4'b0000));

endmodule

`default_nettype wire

//--- dcache/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tag_store (
  input  logic                  clk,
  input  logic                  rst,
  input  dcache_pkg::dc_index_t index_i,
  input  dcache_pkg::dc_tag_t   tag_i,
  input  logic                  wen_i,
  input  logic                  dirty_i,
  output logic                  hit_o,
  output logic                  dirty_o,
  output dcache_pkg::dc_tag_t   tag_o
);
  import dcache_pkg::*;

  logic [`DC_LINES-1:0] valid;
  logic [`DC_LINES-1:0] dirty;
  dc_tag_t              tag_arr [0:`DC_LINES-1];

  logic                 line_valid;
  dc_tag_t              line_tag;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= '0; // all lines invalid
    end else if (wen_i) begin
      valid[index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wen_i) begin
      tag_arr[index_i] <= tag_i;
      dirty[index_i]   <= dirty_i;
    end
  end

  assign line_valid = valid[index_i];
  assign line_tag   = tag_arr[index_i];

  assign hit_o   = line_valid && (line_tag == tag_i);
  assign dirty_o = line_valid && dirty[index_i]; // stale dirty bits never leak
  assign tag_o   = line_tag;

endmodule

`default_nettype wire

//--- dcache/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  logic        clk,
  input  logic        rst,
  // cpu side
  input  logic        mem_valid_i,
  input  logic        mem_write_i,
  input  logic [31:0] mem_addr_i,
  input  logic [3:0]  mem_mask_i,
  input  logic [3:0]  mem_size_i,
  input  logic [31:0] mem_wdata_i,
  output logic [31:0] mem_rdata_o,
  output logic        mem_ready_o,
  // memory read channel
  output logic [31:0] ram_raddr_o,
  output logic        ram_raddr_valid_o,
  output logic [7:0]  ram_rlen_o,
  output logic [3:0]  ram_rsize_o,
  input  logic        ram_rdata_ready_i,
  input  logic [31:0] ram_rdata_i,
  // memory write channel
  output logic [31:0] ram_waddr_o,
  output logic        ram_waddr_valid_o,
  output logic [3:0]  ram_wmask_o,
  output logic [3:0]  ram_wsize_o,
  output logic [7:0]  ram_wlen_o,
  output logic [31:0] ram_wdata_o,
  input  logic        ram_wdata_ready_i
);
  import dcache_pkg::*;

  dc_index_t    line_index;
  dc_tag_t      req_tag;
  dc_tag_t      stored_tag;
  dc_word_sel_t word_sel;
  logic         tag_wen;
  logic         dirty_wr;
  logic         line_hit;
  logic         line_dirty;
  logic         data_wen;
  logic [3:0]   data_wmask;
  logic [31:0]  data_wdata;
  logic [31:0]  line_word;

  dcache_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .mem_valid_i      (mem_valid_i),
    .mem_write_i      (mem_write_i),
    .mem_addr_i       (mem_addr_i),
    .mem_mask_i       (mem_mask_i),
    .mem_size_i       (mem_size_i),
    .mem_wdata_i      (mem_wdata_i),
    .mem_rdata_o      (mem_rdata_o),
    .mem_ready_o      (mem_ready_o),
    .ram_raddr_o      (ram_raddr_o),
    .ram_raddr_valid_o(ram_raddr_valid_o),
    .ram_rlen_o       (ram_rlen_o),
    .ram_rsize_o      (ram_rsize_o),
    .ram_rdata_ready_i(ram_rdata_ready_i),
    .ram_rdata_i      (ram_rdata_i),
    .ram_waddr_o      (ram_waddr_o),
    .ram_waddr_valid_o(ram_waddr_valid_o),
    .ram_wmask_o      (ram_wmask_o),
    .ram_wsize_o      (ram_wsize_o),
    .ram_wlen_o       (ram_wlen_o),
    .ram_wdata_o      (ram_wdata_o),
    .ram_wdata_ready_i(ram_wdata_ready_i),
    .hit_i            (line_hit),
    .dirty_i          (line_dirty),
    .victim_tag_i     (stored_tag),
    .line_word_i      (line_word),
    .tag_index_o      (line_index),
    .tag_o            (req_tag),
    .tag_wen_o        (tag_wen),
    .dirty_o          (dirty_wr),
    .data_word_sel_o  (word_sel),
    .data_wen_o       (data_wen),
    .data_wmask_o     (data_wmask),
    .data_wdata_o     (data_wdata)
  );

  dcache_tag_store u_tag_store (
    .clk    (clk),
    .rst    (rst),
    .index_i(line_index),
    .tag_i  (req_tag),
    .wen_i  (tag_wen),
    .dirty_i(dirty_wr),
    .hit_o  (line_hit),
    .dirty_o(line_dirty),
    .tag_o  (stored_tag)
  );

  // one read port serves cpu reads and write-back
  dcache_data_store u_data_store (
    .clk       (clk),
    .index_i   (line_index),
    .word_sel_i(word_sel),
    .wen_i     (data_wen),
    .wmask_i   (data_wmask),
    .wdata_i   (data_wdata),
    .rdata_o   (line_word)
  );

endmodule

`default_nettype wire

//--- sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache;
  import dcache_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int N_RAND_RD    = 40;
  localparam int N_WR_ROUNDS  = 30;
  localparam int N_UNC        = 20;
  // one read, random reads, write plus two reads, eviction, uncached triples
  localparam int N_REQ       = 1 + N_RAND_RD + 3 * N_WR_ROUNDS + 3 + 3 * N_UNC;
  localparam int CYCLE_LIMIT = N_REQ * 200 + RESET_CYCLES;

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [8:0]  beats;
    logic [3:0]  mask;
    logic [3:0]  size;
  } burst_t;

  logic        clk;
  logic        rst;
  logic        mem_valid;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [3:0]  mem_mask;
  logic [3:0]  mem_size;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic [31:0] ram_raddr;
  logic        ram_raddr_valid;
  logic [7:0]  ram_rlen;
  logic [3:0]  ram_rsize;
  logic        ram_rdata_ready;
  logic [31:0] ram_rdata;
  logic [31:0] ram_waddr;
  logic        ram_waddr_valid;
  logic [3:0]  ram_wmask;
  logic [3:0]  ram_wsize;
  logic [7:0]  ram_wlen;
  logic [31:0] ram_wdata;
  logic        ram_wdata_ready;
  logic        done;
  logic        done_write;
  logic [31:0] done_addr;
  logic [7:0]  done_len;
  logic [8:0]  done_beats;
  logic [3:0]  done_mask;
  logic [3:0]  done_size;

  logic [31:0] model [logic [29:0]];
  burst_t      bursts [$];
  logic [3:0]  wb_beat = '0;
  int          cycles  = 0;
  int          checks  = 0;
  int          errors  = 0;

  dcache_top UUT (
    .clk(clk), .rst(rst),
    .mem_valid_i(mem_valid), .mem_write_i(mem_write), .mem_addr_i(mem_addr),
    .mem_mask_i(mem_mask), .mem_size_i(mem_size), .mem_wdata_i(mem_wdata),
    .mem_rdata_o(mem_rdata), .mem_ready_o(mem_ready),
    .ram_raddr_o(ram_raddr), .ram_raddr_valid_o(ram_raddr_valid), .ram_rlen_o(ram_rlen),
    .ram_rsize_o(ram_rsize), .ram_rdata_ready_i(ram_rdata_ready), .ram_rdata_i(ram_rdata),
    .ram_waddr_o(ram_waddr), .ram_waddr_valid_o(ram_waddr_valid), .ram_wmask_o(ram_wmask),
    .ram_wsize_o(ram_wsize), .ram_wlen_o(ram_wlen), .ram_wdata_o(ram_wdata),
    .ram_wdata_ready_i(ram_wdata_ready)
  );

  tb_mem_slave u_mem (
    .clk(clk), .rst(rst),
    .raddr_i(ram_raddr), .raddr_valid_i(ram_raddr_valid), .rlen_i(ram_rlen),
    .rsize_i(ram_rsize), .rdata_ready_o(ram_rdata_ready), .rdata_o(ram_rdata),
    .waddr_i(ram_waddr), .waddr_valid_i(ram_waddr_valid), .wmask_i(ram_wmask),
    .wsize_i(ram_wsize), .wlen_i(ram_wlen), .wdata_i(ram_wdata),
    .wdata_ready_o(ram_wdata_ready),
    .done_o(done), .done_write_o(done_write), .done_addr_o(done_addr),
    .done_len_o(done_len), .done_beats_o(done_beats), .done_mask_o(done_mask),
    .done_size_o(done_size)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the cache stopped answering after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (model.exists(addr[31:2])) begin
      return model[addr[31:2]];
    end
    return {addr[31:2], 2'b00} ^ 32'h5A5A5A5A;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] data);
    logic [31:0] cur;
    cur = model_read(addr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        cur[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    model[addr[31:2]] = cur;
  endtask

  task automatic check_rdata(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got=%h exp=%h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input dc_addr_u got, input dc_addr_u exp);
    checks++;
    if (got.raw !== exp.raw) begin
      errors++;
      $display("FAIL %s got=%h exp=%h", name, got.raw, exp.raw);
    end
  endtask

  task automatic check_len(input string name, input logic [8:0] got, input logic [8:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got=%h exp=%h", name, got, exp);
    end
  endtask

  task automatic check_code(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got=%h exp=%h", name, got, exp);
    end
  endtask

  // bus monitor, sampled away from the active edge
  always @(negedge clk) begin
    if (done) begin
      bursts.push_back({done_write, done_addr, done_len, done_beats, done_mask, done_size});
    end
    if (ram_waddr_valid && ram_wdata_ready && (ram_wlen == 8'd15)) begin
      check_rdata("ram_wdata_o", ram_wdata, model_read(ram_waddr + (32'(wb_beat) << 2)));
      wb_beat = wb_beat + 4'd1;
    end
  end

  task automatic check_quiet();
    check_code("mem_ready_o", 4'(mem_ready), 4'h0);
    check_code("ram_raddr_valid_o", 4'(ram_raddr_valid), 4'h0);
    check_code("ram_waddr_valid_o", 4'(ram_waddr_valid), 4'h0);
  endtask

  task automatic access(input logic wr, input logic [31:0] addr, input logic [3:0] mask,
                        input logic [3:0] size, input logic [31:0] wdata);
    @(posedge clk);
    mem_valid <= 1'b1;
    mem_write <= wr;
    mem_addr  <= addr;
    mem_mask  <= mask;
    mem_size  <= size;
    mem_wdata <= wdata;
    @(negedge clk);
    while (!mem_ready) @(negedge clk);
    if (wr) begin
      model_write(addr, mask, wdata);
    end else begin
      check_rdata("mem_rdata_o", mem_rdata, model_read(addr));
    end
    @(posedge clk);
    mem_valid <= 1'b0;
  endtask

  task automatic expect_burst(input logic wr, input logic [31:0] addr, input logic [7:0] len,
                              input logic [3:0] size, input logic [3:0] mask);
    burst_t got;
    if (bursts.size() == 0) begin
      errors++;
      $display("missing %s burst to %h", wr ? "write" : "read", addr);
      return;
    end
    got = bursts.pop_front();
    if (got.wr != wr) begin
      errors++;
      $display("burst to %h went in the wrong direction", got.addr);
    end
    check_addr(wr ? "ram_waddr_o" : "ram_raddr_o", got.addr, addr);
    check_len(wr ? "ram_wlen_o" : "ram_rlen_o", {1'b0, got.len}, {1'b0, len});
    check_len("burst beats", got.beats, {1'b0, len} + 9'd1);
    check_code(wr ? "ram_wsize_o" : "ram_rsize_o", got.size, size);
    if (wr) begin
      check_code("ram_wmask_o", got.mask, mask);
    end
  endtask

  task automatic expect_no_burst();
    if (bursts.size() != 0) begin
      errors++;
      $display("unexpected extra burst to %h", bursts[0].addr);
      bursts.delete();
    end
  endtask

  function automatic logic [31:0] line_of(input dc_addr_u a);
    a.f.word_sel = '0;
    a.f.byte_sel = 2'b00;
    return a.raw;
  endfunction

  // a few indexes, a few tags, so lines get shared and evicted
  function automatic dc_addr_u rand_cached_addr();
    dc_addr_u a;
    a.f.tag      = dc_tag_t'(($urandom % 6) + 1);
    a.f.index    = dc_index_t'((($urandom % 3) * 23) + 3);
    a.f.word_sel = dc_word_sel_t'($urandom % 16);
    a.f.byte_sel = 2'b00;
    return a;
  endfunction

  task automatic unc_access(input logic wr, input logic [31:0] addr, input logic [3:0] mask,
                            input logic [3:0] size);
    logic [31:0] data;
    data = $urandom;
    bursts.delete();
    access(wr, addr, mask, size, data);
    expect_burst(wr, addr, 8'd0, size, mask);
    expect_no_burst();
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("test %-9s %s", name, (errors == err_start) ? "ok" : "failed");
  endtask

  initial begin
    dc_addr_u    a;
    dc_addr_u    b;
    logic [31:0] u;
    logic [3:0]  mask;
    logic [3:0]  size;
    int          err_start;
    void'($urandom(32'he9647645));
    rst       = 1'b1;
    mem_valid = 1'b0;
    mem_write = 1'b0;
    mem_addr  = '0;
    mem_mask  = '0;
    mem_size  = '0;
    mem_wdata = '0;

    err_start = errors;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_quiet();
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_quiet();
    end
    bursts.delete();
    access(1'b0, 32'h0000_1234, 4'hF, `DC_SIZE_WORD, '0);
    expect_burst(1'b0, 32'h0000_1200, 8'd15, `DC_SIZE_WORD, 4'hF);
    expect_no_burst();
    report_test("reset", err_start);

    err_start = errors;
    repeat (N_RAND_RD) begin
      a = rand_cached_addr();
      access(1'b0, a.raw, 4'hF, `DC_SIZE_WORD, '0);
    end
    report_test("reads", err_start);

    err_start = errors;
    repeat (N_WR_ROUNDS) begin
      a    = rand_cached_addr();
      mask = 4'(($urandom % 15) + 1);
      access(1'b1, a.raw, mask, `DC_SIZE_WORD, $urandom);
      access(1'b0, a.raw, 4'hF, `DC_SIZE_WORD, '0);
      access(1'b0, a.raw + 32'd4, 4'hF, `DC_SIZE_WORD, '0); // may cross into the next line
    end
    report_test("writes", err_start);

    err_start = errors;
    a.f.tag      = dc_tag_t'(9);
    a.f.index    = dc_index_t'(100);
    a.f.word_sel = dc_word_sel_t'(5);
    a.f.byte_sel = 2'b00;
    b            = a;
    b.f.tag      = dc_tag_t'(10);
    access(1'b1, a.raw, 4'b0110, `DC_SIZE_WORD, $urandom);
    bursts.delete();
    access(1'b0, b.raw, 4'hF, `DC_SIZE_WORD, '0);
    expect_burst(1'b1, line_of(a), 8'd15, `DC_SIZE_WORD, 4'hF);
    expect_burst(1'b0, line_of(b), 8'd15, `DC_SIZE_WORD, 4'hF);
    expect_no_burst();
    access(1'b0, a.raw, 4'hF, `DC_SIZE_WORD, '0);
    expect_burst(1'b0, line_of(a), 8'd15, `DC_SIZE_WORD, 4'hF); // b is clean
    expect_no_burst();
    report_test("eviction", err_start);

    err_start = errors;
    repeat (N_UNC) begin
      u    = `DC_UNCACHE_BASE + (($urandom % 32) << 2);
      mask = 4'(($urandom % 15) + 1);
      size = 4'(1 << ($urandom % 3));
      unc_access(1'b1, u, mask, size);
      unc_access(1'b0, u, 4'hF, size);
      unc_access(1'b0, u + 32'd4, 4'hF, size);
    end
    report_test("uncached", err_start);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tb_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_slave (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] raddr_i,
  input  logic        raddr_valid_i,
  input  logic [7:0]  rlen_i,
  input  logic [3:0]  rsize_i,
  output logic        rdata_ready_o,
  output logic [31:0] rdata_o,
  input  logic [31:0] waddr_i,
  input  logic        waddr_valid_i,
  input  logic [3:0]  wmask_i,
  input  logic [3:0]  wsize_i,
  input  logic [7:0]  wlen_i,
  input  logic [31:0] wdata_i,
  output logic        wdata_ready_o,
  // one pulse per finished transfer
  output logic        done_o,
  output logic        done_write_o,
  output logic [31:0] done_addr_o,
  output logic [7:0]  done_len_o,
  output logic [8:0]  done_beats_o,
  output logic [3:0]  done_mask_o,
  output logic [3:0]  done_size_o
);

  logic [31:0] words [logic [29:0]];
  logic [8:0]  rbeat;
  logic [8:0]  wbeat;
  logic        rd_acc;
  logic        wr_acc;

  assign rd_acc = raddr_valid_i && rdata_ready_o;
  assign wr_acc = waddr_valid_i && wdata_ready_o;

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (words.exists(addr[31:2])) begin
      return words[addr[31:2]];
    end
    return {addr[31:2], 2'b00} ^ 32'h5A5A5A5A; // untouched memory
  endfunction

  function automatic logic [31:0] beat_addr(input logic [31:0] base, input logic [8:0] beat);
    return base + (32'(beat) << 2);
  endfunction

  task automatic store_beat(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
    logic [31:0] cur;
    cur = read_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        cur[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    words[addr[31:2]] = cur;
  endtask

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      rdata_ready_o <= 1'b0;
      wdata_ready_o <= 1'b0;
      rdata_o       <= '0;
      rbeat         <= '0;
      wbeat         <= '0;
      done_o        <= 1'b0;
      done_write_o  <= 1'b0;
      done_addr_o   <= '0;
      done_len_o    <= '0;
      done_beats_o  <= '0;
      done_mask_o   <= '0;
      done_size_o   <= '0;
    end else begin
      done_o <= 1'b0;
      if (rd_acc && (rbeat == {1'b0, rlen_i})) begin
        rbeat         <= '0;
        rdata_ready_o <= 1'b0;
        done_o        <= 1'b1;
        done_write_o  <= 1'b0;
        done_addr_o   <= raddr_i;
        done_len_o    <= rlen_i;
        done_beats_o  <= rbeat + 9'd1;
        done_mask_o   <= 4'hF;
        done_size_o   <= rsize_i;
      end else if (raddr_valid_i) begin
        if (rd_acc) begin
          rbeat <= rbeat + 9'd1;
        end
        rdata_o       <= read_word(beat_addr(raddr_i, rd_acc ? rbeat + 9'd1 : rbeat));
        rdata_ready_o <= ($urandom % 4) != 0; // random stalls
      end
      if (wr_acc) begin
        store_beat(beat_addr(waddr_i, wbeat), wdata_i, wmask_i);
      end
      if (wr_acc && (wbeat == {1'b0, wlen_i})) begin
        wbeat         <= '0;
        wdata_ready_o <= 1'b0;
        done_o        <= 1'b1;
        done_write_o  <= 1'b1;
        done_addr_o   <= waddr_i;
        done_len_o    <= wlen_i;
        done_beats_o  <= wbeat + 9'd1;
        done_mask_o   <= wmask_i;
        done_size_o   <= wsize_i;
      end else if (waddr_valid_i) begin
        if (wr_acc) begin
          wbeat <= wbeat + 9'd1;
        end
        wdata_ready_o <= ($urandom % 4) != 0;
      end
    end
  end

endmodule

`default_nettype wire
